/* sim/arb_vectors.txt */
# test <name> <out_stall mode: never, hold or random> <out_stall cycles for hold>
# word <input> <data hex> | run <input> <count> <first data hex> | expect <data hex>

test single_in never 0
word 2 2a01
word 2 2a02
word 2 2b03
word 2 2c04
word 2 2d05
word 2 2e06
expect 2a01
expect 2a02
expect 2b03
expect 2c04
expect 2d05
expect 2e06

test all_four never 0
word 0 0f00
word 1 1f01
word 2 2f02
word 3 3f03
expect 0f00
expect 1f01
expect 2f02
expect 3f03

test stall_fill hold 24
word 0 c000
word 0 c001
word 0 c002
word 0 c003
word 1 c100
word 1 c101
word 1 c102
word 1 c103
word 2 c200
word 2 c201
word 2 c202
word 2 c203
word 3 c300
word 3 c301
word 3 c302
word 3 c303

test random_long random 0
run 0 40 4000
run 1 40 5000
run 2 40 6000
run 3 40 7000

test random_uneven random 0
run 0 12 8000
run 1 50 9000
run 2 3 a000
run 3 25 b000

test hold_short hold 6
word 0 d000
word 1 d100
word 1 d101
word 3 d300
run 2 5 d200

/* vlog.f */
+incdir+include
source/arb_pkg.sv
source/skid_buf.sv
source/rr_pointer.sv
source/rr_grant.sv
source/arb_fifo.sv
source/rr_arbiter.sv
sim/tb_rr_arbiter.sv

/* sim/tb_rr_arbiter.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module tb_rr_arbiter;

  localparam int MAX_TESTS = 8;
  localparam int MAX_WORDS = 64;

  logic                   clk;
  logic                   rst;
  arb_pkg::stream_vec_t   in_streams;
  logic [`ARB_NUM_IN-1:0] in_stall;
  arb_pkg::stream_t       out_stream;
  logic                   out_stall;

  // test records as read from the vector file
  string          test_name [MAX_TESTS];
  string          test_mode [MAX_TESTS];
  int             test_arg  [MAX_TESTS];   // out_stall cycles in hold mode
  arb_pkg::data_t src_mem   [MAX_TESTS][`ARB_NUM_IN][MAX_WORDS];
  int             src_cnt   [MAX_TESTS][`ARB_NUM_IN];
  arb_pkg::data_t exp_mem   [MAX_TESTS][MAX_WORDS];
  int             exp_cnt   [MAX_TESTS];
  int             num_tests;
  int             total_words;

  int          err_cnt      = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles       = 0;
  int          cycle_limit  = 100;
  logic [31:0] lfsr_state   = 32'h9afc_d71e;

  rr_arbiter i_dut (
    .clk        (clk),
    .rst        (rst),
    .in_streams (in_streams),
    .in_stall   (in_stall),
    .out_stream (out_stream),
    .out_stall  (out_stall)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  initial begin
    wait (cycles >= cycle_limit);
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("sim failed");
    $finish;
  end

  // galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  task automatic compare_data(input string name, input arb_pkg::data_t expected,
                              input arb_pkg::data_t actual);
    if (actual !== expected) begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic compare_stall(input string name, input logic [`ARB_NUM_IN-1:0] expected,
                               input logic [`ARB_NUM_IN-1:0] actual);
    if (actual !== expected) begin
      $display("Fail %s expected %b actual %b", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic report_problem(input string name, input string what);
    $display("%s: %s", name, what);
    err_cnt++;
  endtask

  task automatic load_vectors(output bit ok);
    int          fd;
    int          r;
    int          t;
    int          inp;
    int          cnt;
    int          arg;
    logic [31:0] value;
    string       line;
    string       kind;
    string       name;
    string       mode;
    ok = 1'b1;
    total_words = 0;
    t = -1;
    fd = $fopen("sim/arb_vectors.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
      return;
    end
    while (!$feof(fd) && ok) begin
      line = "";
      kind = "";
      r = $fgets(line, fd);
      if (r > 0) begin
        r = $sscanf(line, "%s", kind);
      end
      if (r < 1 || kind.len() == 0 || kind.substr(0, 0) == "#") begin
        // blank or comment line
      end else if (kind == "test" && t < MAX_TESTS - 1) begin
        r = $sscanf(line, "%s %s %s %d", kind, name, mode, arg);
        t++;
        test_name[t] = name;
        test_mode[t] = mode;
        test_arg[t]  = arg;
        exp_cnt[t]   = 0;
        for (int i = 0; i < `ARB_NUM_IN; i++) begin
          src_cnt[t][i] = 0;
        end
      end else if (kind == "word" && t >= 0) begin
        r = $sscanf(line, "%s %d %h", kind, inp, value);
        ok = (r == 3) && (inp < `ARB_NUM_IN) && (src_cnt[t][inp] < MAX_WORDS);
        if (ok) begin
          src_mem[t][inp][src_cnt[t][inp]] = arb_pkg::data_t'(value);
          src_cnt[t][inp]++;
          total_words++;
        end
      end else if (kind == "run" && t >= 0) begin
        r = $sscanf(line, "%s %d %d %h", kind, inp, cnt, value);
        ok = (r == 4) && (inp < `ARB_NUM_IN) && (src_cnt[t][inp] + cnt <= MAX_WORDS);
        for (int k = 0; ok && k < cnt; k++) begin
          src_mem[t][inp][src_cnt[t][inp]] = arb_pkg::data_t'(value + k);
          src_cnt[t][inp]++;
          total_words++;
        end
      end else if (kind == "expect" && t >= 0 && exp_cnt[t] < MAX_WORDS) begin
        r = $sscanf(line, "%s %h", kind, value);
        exp_mem[t][exp_cnt[t]] = arb_pkg::data_t'(value);
        exp_cnt[t]++;
      end else begin
        ok = 1'b0;
      end
    end
    $fclose(fd);
    num_tests = t + 1;
    ok = ok && (num_tests > 0);
  endtask

  task automatic apply_reset(input string name);
    rst        <= 1'b1;
    in_streams <= '0;
    out_stall  <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (out_stream.valid !== 1'b0) begin
      report_problem(name, "out_stream valid is not low after reset");
    end
    compare_stall(name, '0, in_stall);
  endtask

  task automatic run_test(input int t);
    string                  name;
    int                     errs_before;
    int                     want;
    int                     got;
    int                     exp_pos;
    int                     cyc;
    int                     sent  [`ARB_NUM_IN];
    int                     recv  [`ARB_NUM_IN];
    bit                     shown [`ARB_NUM_IN];   // a word is waiting on this input
    bit                     matched;
    logic [`ARB_NUM_IN-1:0] waiting;
    arb_pkg::data_t         word;
    name = test_name[t];
    errs_before = err_cnt;
    want = 0;
    got = 0;
    exp_pos = 0;
    cyc = 0;
    for (int i = 0; i < `ARB_NUM_IN; i++) begin
      sent[i]  = 0;
      recv[i]  = 0;
      shown[i] = 1'b0;
      want += src_cnt[t][i];
    end
    apply_reset(name);
    while (got < want) begin
      @(posedge clk);
      for (int i = 0; i < `ARB_NUM_IN; i++) begin
        if (!shown[i]) begin
          if (sent[i] < src_cnt[t][i] && (test_mode[t] != "random" || take_bit())) begin
            in_streams[i].valid <= 1'b1;
            in_streams[i].data  <= src_mem[t][i][sent[i]];
            shown[i] = 1'b1;
          end else begin
            in_streams[i] <= '0;
          end
        end
      end
      if (test_mode[t] == "hold") begin
        out_stall <= (cyc < test_arg[t]);
      end else if (test_mode[t] == "random") begin
        out_stall <= take_bit();
      end else begin
        out_stall <= 1'b0;
      end
      @(negedge clk);
      if (test_mode[t] == "hold" && cyc == test_arg[t] - 1) begin
        for (int i = 0; i < `ARB_NUM_IN; i++) begin
          waiting[i] = (sent[i] < src_cnt[t][i]);
        end
        compare_stall(name, waiting, in_stall & waiting); // inputs with words left backed up
      end
      for (int i = 0; i < `ARB_NUM_IN; i++) begin
        if (in_streams[i].valid && !in_stall[i]) begin // taken on the coming edge
          sent[i]++;
          shown[i] = 1'b0;
        end
      end
      if (out_stream.valid && !out_stall) begin
        word = out_stream.data;
        if (exp_pos < exp_cnt[t]) begin
          compare_data(name, exp_mem[t][exp_pos], word);
        end
        exp_pos++;
        matched = 1'b0;
        // each input's words must leave in the order they were sent
        for (int i = 0; i < `ARB_NUM_IN; i++) begin
          if (!matched && recv[i] < src_cnt[t][i] && src_mem[t][i][recv[i]] == word) begin
            recv[i]++;
            matched = 1'b1;
          end
        end
        if (!matched) begin
          report_problem(name, $sformatf("output word %h is not the next word of any input",
                                         word));
        end
        got++;
      end
      cyc++;
    end
    @(posedge clk);
    in_streams <= '0;
    out_stall  <= 1'b0;
    @(negedge clk);
    if (out_stream.valid) begin
      report_problem(name, "output still valid after every sent word arrived");
    end
    if (exp_cnt[t] > 0 && exp_pos != exp_cnt[t]) begin
      report_problem(name, $sformatf("%0d words came out, the fixed order lists %0d",
                                     exp_pos, exp_cnt[t]));
    end
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("test %s done, %0d words delivered", name, got);
    end else begin
      tests_failed++;
      $display("test %s done with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    bit loaded;
    rst        = 1'b1;
    in_streams = '0;
    out_stall  = 1'b0;
    load_vectors(loaded);
    if (loaded) begin
      cycle_limit = 20 * total_words + 100;
      for (int t = 0; t < num_tests; t++) begin
        run_test(t);
      end
    end else begin
      report_problem("vectors", "sim/arb_vectors.txt is missing or has a bad line");
    end
    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, err_cnt);
    if (loaded && err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* source/rr_arbiter.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module rr_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  arb_pkg::stream_vec_t   in_streams,
  output logic [`ARB_NUM_IN-1:0] in_stall,
  output arb_pkg::stream_t       out_stream,
  input  logic                   out_stall
);

  arb_pkg::stream_vec_t   buf_streams;  // skid buffer outputs, grant candidates
  logic [`ARB_NUM_IN-1:0] grant_stall;
  arb_pkg::idx_t          start;
  logic                   granted;
  arb_pkg::stream_t       fifo_wr;
  logic                   fifo_full;

  generate
    for (genvar i = 0; i < `ARB_NUM_IN; i++) begin : g_in
      skid_buf i_skid (
        .clk,
        .rst,
        .up         (in_streams[i]),
        .up_stall   (in_stall[i]),
        .down       (buf_streams[i]),
        .down_stall (grant_stall[i])
      );
    end
  endgenerate

  rr_pointer i_ptr (
    .clk,
    .rst,
    .advance (granted),
    .start   (start)
  );

  rr_grant i_grant (
    .cand       (buf_streams),
    .start      (start),
    .fifo_full  (fifo_full),
    .cand_stall (grant_stall),
    .wr         (fifo_wr),
    .granted    (granted)
  );

  // head of the queue is the arbiter output
  arb_fifo i_fifo (
    .clk,
    .rst,
    .wr         (fifo_wr),
    .full       (fifo_full),
    .head       (out_stream),
    .head_stall (out_stall)
  );

endmodule

/* source/arb_fifo.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module arb_fifo (
  input  logic             clk,
  input  logic             rst,
  input  arb_pkg::stream_t wr,
  output logic             full,
  output arb_pkg::stream_t head,
  input  logic             head_stall
);

  localparam int PTR_W = $clog2(`ARB_FIFO_DEPTH);

  arb_pkg::data_t        mem [`ARB_FIFO_DEPTH];
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W-1:0]      wr_ptr;
  logic [`ARB_CNT_W-1:0] count;      // words currently stored
  logic                  do_wr;
  logic                  do_rd;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`ARB_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // head of queue falls through, valid whenever something is stored
  assign head.valid = (count != '0);
  assign head.data  = mem[rd_ptr];

  assign full  = (count == `ARB_CNT_W'(`ARB_FIFO_DEPTH));
  assign do_wr = wr.valid && !full;
  assign do_rd = head.valid && !head_stall;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr.data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  // read and write together leave the count alone
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the grant side must already have seen full and held off
  a_no_write_full: assert property (
    @(posedge clk) disable iff (rst)
    wr.valid |-> !full
  );

  a_count_bound: assert property (
    @(posedge clk) disable iff (rst)
    count <= `ARB_CNT_W'(`ARB_FIFO_DEPTH)
  );

endmodule

/* source/rr_grant.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module rr_grant (
  input  arb_pkg::stream_vec_t    cand,
  input  arb_pkg::idx_t           start,
  input  logic                    fifo_full,
  output logic [`ARB_NUM_IN-1:0]  cand_stall,
  output arb_pkg::stream_t        wr,
  output logic                    granted
);

  logic [`ARB_NUM_IN-1:0] cand_valid;
  logic [`ARB_NUM_IN-1:0] sel;        // one-hot winner, zero when no grant

  always_comb begin
    for (int i = 0; i < `ARB_NUM_IN; i++) begin
      cand_valid[i] = cand[i].valid;
    end
  end

  // scan from start upward with wrap, first valid candidate wins
  always_comb begin
    arb_pkg::idx_t idx;
    int            pos;
    sel = '0;
    wr  = '0;
    for (int k = 0; k < `ARB_NUM_IN; k++) begin
      pos = int'(start) + k;
      if (pos >= `ARB_NUM_IN) begin
        pos = pos - `ARB_NUM_IN;
      end
      idx = arb_pkg::idx_t'(pos);
      if (!fifo_full && !wr.valid && cand_valid[idx]) begin
        sel[idx] = 1'b1;
        wr.valid = 1'b1;
        wr.data  = cand[idx].data;
      end
    end
  end

  assign granted    = wr.valid;
  assign cand_stall = cand_valid & ~sel; // losers hold their word

  // exactly the written word leaves a skid buffer, never two
  a_one_winner: assert final ($onehot0(cand_valid & ~cand_stall)
                              && ((|(cand_valid & ~cand_stall)) == granted));

endmodule

/* source/rr_pointer.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module rr_pointer (
  input  logic          clk,
  input  logic          rst,
  input  logic          advance,
  output arb_pkg::idx_t start
);

  arb_pkg::idx_t start_n;

  // step to the next input, wrapping after the last one
  assign start_n = (start == arb_pkg::idx_t'(`ARB_NUM_IN - 1)) ? '0 : start + 1'b1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start <= '0;
    end else if (advance) begin // only cycles with a grant rotate priority
      start <= start_n;
    end
  end

endmodule

/* source/skid_buf.sv */
`timescale 1ns/1ps

module skid_buf (
  input  logic             clk,
  input  logic             rst,
  input  arb_pkg::stream_t up,
  output logic             up_stall,
  output arb_pkg::stream_t down,
  input  logic             down_stall
);

  logic           hold_full;   // set in HOLD, clear in PASS
  logic           hold_full_n;
  logic           capture;
  arb_pkg::data_t hold_data;

  // an upstream word refused downstream while passing straight through
  assign capture = !hold_full && up.valid && down_stall;

  always_comb begin
    case (hold_full)
      1'b0: hold_full_n = capture;
      1'b1: hold_full_n = down_stall; // leave HOLD once the held word moves on
      default: hold_full_n = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hold_full <= 1'b0;
    end else begin
      hold_full <= hold_full_n;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      hold_data <= up.data;
    end
  end

  // held word first, otherwise zero-cycle pass of the upstream word
  assign down.valid = hold_full | up.valid;
  assign down.data  = hold_full ? hold_data : up.data;

  // upstream sees the stall one cycle after the capture
  assign up_stall = hold_full;

  // a word offered to the grant stays put until it is taken,
  // whether it came straight through or out of the hold register
  a_offer_stable: assert property (
    @(posedge clk) disable iff (rst)
    down.valid && down_stall |=> down.valid && (down.data == $past(down.data))
  );

endmodule

/* source/arb_pkg.sv */
`include "arb_defines.svh"

package arb_pkg;

  typedef logic [`ARB_DATA_W-1:0] data_t;

  typedef logic [`ARB_IDX_W-1:0] idx_t;

  // forward half of a valid/stall link, the stall runs the other way
  typedef struct packed {
    logic  valid;
    data_t data;
  } stream_t;

  // one link per arbitrated input, index 0 in the low bits
  typedef stream_t [`ARB_NUM_IN-1:0] stream_vec_t;

endpackage

/* include/arb_defines.svh */
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// arbiter shape
`define ARB_NUM_IN 4
`define ARB_DATA_W 16

// output queue
`define ARB_FIFO_DEPTH 4

// derived widths
`define ARB_IDX_W 2   // one input index
`define ARB_CNT_W 3   // counts 0 to ARB_FIFO_DEPTH

`endif
